//--- include/dbgu_defines.svh
`ifndef DBGU_DEFINES_SVH
`define DBGU_DEFINES_SVH

// Serial bit period and memory size
`define DBGU_CLKS_PER_BIT 8
`define DBGU_MEM_WORDS    256

// Frame start bytes
`define DBGU_SOF          8'hA5
`define DBGU_RSOF         8'h5A

// Command codes
`define DBGU_CMD_WR32     8'h10
`define DBGU_CMD_RD32     8'h11
`define DBGU_CMD_RUN      8'h12
`define DBGU_CMD_HALT     8'h13
`define DBGU_CMD_RDREG    8'h14

// Answer codes
`define DBGU_R_ACK        8'h90
`define DBGU_R_RD         8'h91
`define DBGU_R_RDREG      8'h92

// Acknowledge status values
`define DBGU_ST_OK        8'h00
`define DBGU_ST_CHK       8'h01
`define DBGU_ST_BUSY      8'h02
`define DBGU_ST_CMD       8'h03

`endif

//--- src/dbgu_pkg.sv
`default_nettype none

package dbgu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Debug bus request toward the local memory
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } dbg_bus_req_t;

    typedef enum logic [4:0] {
        S_WAIT_SOF = 5'd0,
        S_CMD      = 5'd1,
        S_A0       = 5'd2,
        S_A1       = 5'd3,
        S_A2       = 5'd4,
        S_A3       = 5'd5,
        S_D0       = 5'd6,
        S_D1       = 5'd7,
        S_D2       = 5'd8,
        S_D3       = 5'd9,
        S_REG      = 5'd10,
        S_CHK      = 5'd11,
        S_DO_WR    = 5'd12,
        S_DO_RD0   = 5'd13,
        S_DO_RD1   = 5'd14,
        S_SEND     = 5'd15
    } cmd_state_t;

endpackage

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbgu_defines.svh"

module uart_rx (
    input  logic            clk,
    input  logic            rst,
    input  logic            rx,
    output dbgu_pkg::byte_t rx_data,
    output logic            rx_valid,
    input  logic            rx_ready
);

    localparam int CLKS = `DBGU_CLKS_PER_BIT;
    localparam int CW   = $clog2(CLKS);

    logic            rx_m;
    logic            rx_s;
    logic            busy;
    logic [CW-1:0]   cyc_cnt;
    logic [3:0]      bit_cnt;
    dbgu_pkg::byte_t shreg;
    logic            tick;
    logic            done;

    // Bit 0 is the start bit, 1 to 8 data, 9 the stop bit
    assign tick = busy && (cyc_cnt == '0);
    assign done = tick && (bit_cnt == 4'd9);

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_m     <= 1'b1;
            rx_s     <= 1'b1;
            busy     <= 1'b0;
            cyc_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_m <= rx;
            rx_s <= rx_m;
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end
            if (done) begin
                rx_valid <= 1'b1;
            end
            if (!busy) begin
                if (!rx_s) begin
                    // First sample lands in the middle of the start bit
                    busy    <= 1'b1;
                    cyc_cnt <= CW'(CLKS / 2 - 1);
                    bit_cnt <= '0;
                end
            end else if (tick) begin
                cyc_cnt <= CW'(CLKS - 1);
                bit_cnt <= bit_cnt + 4'd1;
                if ((bit_cnt == 4'd0 && rx_s) || bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                end
            end else begin
                cyc_cnt <= cyc_cnt - 1'b1;
            end
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (tick && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            shreg <= {rx_s, shreg[7:1]};
        end
        if (done) begin
            rx_data <= shreg;
        end
    end

    a_rx_hold: assert property (@(posedge clk) disable iff (rst)
        (rx_valid && !rx_ready && !done) |=> $stable(rx_data));

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbgu_defines.svh"

module uart_tx (
    input  logic            clk,
    input  logic            rst,
    input  dbgu_pkg::byte_t tx_data,
    input  logic            tx_valid,
    output logic            tx_ready,
    output logic            tx
);

    localparam int CLKS = `DBGU_CLKS_PER_BIT;
    localparam int CW   = $clog2(CLKS);

    logic          busy;
    logic [CW-1:0] cyc_cnt;
    logic [3:0]    bit_cnt;
    logic [9:0]    shreg;
    logic          shift;

    assign tx_ready = !busy;
    assign tx       = busy ? shreg[0] : 1'b1;
    assign shift    = busy && (cyc_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            cyc_cnt <= '0;
            bit_cnt <= '0;
        end else if (tx_valid && tx_ready) begin
            busy    <= 1'b1;
            cyc_cnt <= CW'(CLKS - 1);
            bit_cnt <= 4'd9;
        end else if (shift) begin
            cyc_cnt <= CW'(CLKS - 1);
            if (bit_cnt == 4'd0) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt - 4'd1;
            end
        end else if (busy) begin
            cyc_cnt <= cyc_cnt - 1'b1;
        end
    end

    // Stop, data, start; shifted out from bit 0
    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready) begin
            shreg <= {1'b1, tx_data, 1'b0};
        end else if (shift) begin
            shreg <= {1'b1, shreg[9:1]};
        end
    end

    // Ready stays low for exactly one frame after each accept
    a_tx_accept: assert property (@(posedge clk) disable iff (rst)
        $rose(tx_ready) |-> (!$past(tx_ready, 10 * CLKS) && $past(tx_ready, 10 * CLKS + 1)));

endmodule

`default_nettype wire

//--- src/dbg_cmd_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbgu_defines.svh"

module dbg_cmd_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  dbgu_pkg::byte_t        rx_data,
    input  logic                   rx_valid,
    output logic                   rx_ready,
    output dbgu_pkg::byte_t        tx_data,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output dbgu_pkg::dbg_bus_req_t bus_req,
    input  dbgu_pkg::word_t        bus_rdata,
    output dbgu_pkg::reg_idx_t     reg_idx,
    input  dbgu_pkg::word_t        reg_rdata,
    output logic                   hold_core
);

    typedef dbgu_pkg::byte_t [6:0] resp_buf_t;

    dbgu_pkg::cmd_state_t state;
    dbgu_pkg::byte_t      cmd;
    dbgu_pkg::byte_t      chk_calc;
    dbgu_pkg::byte_t      ack_st;
    dbgu_pkg::word_t      addr_q;
    dbgu_pkg::word_t      wdata_q;
    logic                 we_q;
    resp_buf_t            resp;
    resp_buf_t            resp_next;
    logic [2:0]           resp_len;
    logic [2:0]           resp_len_next;
    logic [2:0]           resp_idx;
    logic                 resp_load;
    logic                 rx_fire;
    logic                 send_go;
    logic                 mem_cmd;
    logic                 cmd_known;

    function automatic resp_buf_t ack_frame(input dbgu_pkg::byte_t st);
        resp_buf_t f;
        f    = '0;
        f[0] = `DBGU_RSOF;
        f[1] = `DBGU_R_ACK;
        f[2] = st;
        f[3] = `DBGU_R_ACK ^ st;
        return f;
    endfunction

    // Data answers are little-endian
    function automatic resp_buf_t data_frame(input dbgu_pkg::byte_t code,
                                             input dbgu_pkg::word_t d);
        resp_buf_t f;
        f[0] = `DBGU_RSOF;
        f[1] = code;
        f[2] = d[7:0];
        f[3] = d[15:8];
        f[4] = d[23:16];
        f[5] = d[31:24];
        f[6] = code ^ d[7:0] ^ d[15:8] ^ d[23:16] ^ d[31:24];
        return f;
    endfunction

    assign rx_ready = (state != dbgu_pkg::S_SEND);
    assign rx_fire  = rx_valid && rx_ready;
    assign send_go  = (state == dbgu_pkg::S_SEND) && !tx_valid && tx_ready;
    assign bus_req  = '{addr: addr_q, wdata: wdata_q, we: we_q};

    assign mem_cmd   = (cmd == `DBGU_CMD_WR32) || (cmd == `DBGU_CMD_RD32);
    assign cmd_known = mem_cmd || (cmd == `DBGU_CMD_RUN) || (cmd == `DBGU_CMD_HALT)
                       || (cmd == `DBGU_CMD_RDREG);

    // Status of the frame whose checksum byte is on rx_data
    always_comb begin
        if (rx_data != chk_calc) begin
            ack_st = `DBGU_ST_CHK;
        end else if (mem_cmd && !hold_core) begin
            ack_st = `DBGU_ST_BUSY;
        end else if (!cmd_known) begin
            ack_st = `DBGU_ST_CMD;
        end else begin
            ack_st = `DBGU_ST_OK;
        end
    end

    always_comb begin
        resp_load     = 1'b0;
        resp_next     = ack_frame(ack_st);
        resp_len_next = 3'd4;
        case (state)
            dbgu_pkg::S_CHK: begin
                // Accepted memory commands answer from the execute states
                if (rx_fire && !(ack_st == `DBGU_ST_OK && mem_cmd)) begin
                    resp_load = 1'b1;
                end
                if (ack_st == `DBGU_ST_OK && cmd == `DBGU_CMD_RDREG) begin
                    resp_next     = data_frame(`DBGU_R_RDREG, reg_rdata);
                    resp_len_next = 3'd7;
                end
            end
            dbgu_pkg::S_DO_WR: begin
                resp_load = 1'b1;
                resp_next = ack_frame(`DBGU_ST_OK);
            end
            dbgu_pkg::S_DO_RD1: begin
                resp_load     = 1'b1;
                resp_next     = data_frame(`DBGU_R_RD, bus_rdata);
                resp_len_next = 3'd7;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= dbgu_pkg::S_WAIT_SOF;
            hold_core <= 1'b1;
            we_q      <= 1'b0;
            tx_valid  <= 1'b0;
            resp_len  <= 3'd0;
            resp_idx  <= 3'd0;
        end else begin
            we_q <= 1'b0;
            if (tx_valid && tx_ready) begin
                tx_valid <= 1'b0;
            end
            case (state)
                dbgu_pkg::S_WAIT_SOF: begin
                    if (rx_fire && rx_data == `DBGU_SOF) begin
                        state <= dbgu_pkg::S_CMD;
                    end
                end
                dbgu_pkg::S_CMD: begin
                    if (rx_fire) begin
                        if (rx_data == `DBGU_CMD_RUN || rx_data == `DBGU_CMD_HALT) begin
                            state <= dbgu_pkg::S_CHK;
                        end else if (rx_data == `DBGU_CMD_RDREG) begin
                            state <= dbgu_pkg::S_REG;
                        end else begin
                            state <= dbgu_pkg::S_A0;
                        end
                    end
                end
                dbgu_pkg::S_A0: if (rx_fire) state <= dbgu_pkg::S_A1;
                dbgu_pkg::S_A1: if (rx_fire) state <= dbgu_pkg::S_A2;
                dbgu_pkg::S_A2: if (rx_fire) state <= dbgu_pkg::S_A3;
                dbgu_pkg::S_A3: begin
                    if (rx_fire) begin
                        if (cmd == `DBGU_CMD_WR32) begin
                            state <= dbgu_pkg::S_D0;
                        end else begin
                            state <= dbgu_pkg::S_CHK;
                        end
                    end
                end
                dbgu_pkg::S_D0: if (rx_fire) state <= dbgu_pkg::S_D1;
                dbgu_pkg::S_D1: if (rx_fire) state <= dbgu_pkg::S_D2;
                dbgu_pkg::S_D2: if (rx_fire) state <= dbgu_pkg::S_D3;
                dbgu_pkg::S_D3: if (rx_fire) state <= dbgu_pkg::S_CHK;
                dbgu_pkg::S_REG: if (rx_fire) state <= dbgu_pkg::S_CHK;
                dbgu_pkg::S_CHK: begin
                    if (rx_fire && ack_st == `DBGU_ST_OK) begin
                        case (cmd)
                            `DBGU_CMD_RUN:  hold_core <= 1'b0;
                            `DBGU_CMD_HALT: hold_core <= 1'b1;
                            `DBGU_CMD_WR32: begin
                                we_q  <= 1'b1;
                                state <= dbgu_pkg::S_DO_WR;
                            end
                            `DBGU_CMD_RD32: state <= dbgu_pkg::S_DO_RD0;
                            default: begin
                            end
                        endcase
                    end
                end
                // Memory read latency
                dbgu_pkg::S_DO_RD0: state <= dbgu_pkg::S_DO_RD1;
                dbgu_pkg::S_DO_WR, dbgu_pkg::S_DO_RD1: begin
                end
                dbgu_pkg::S_SEND: begin
                    if (send_go) begin
                        tx_valid <= 1'b1;
                        if (resp_idx == resp_len - 3'd1) begin
                            state    <= dbgu_pkg::S_WAIT_SOF;
                            resp_idx <= 3'd0;
                        end else begin
                            resp_idx <= resp_idx + 3'd1;
                        end
                    end
                end
                default: state <= dbgu_pkg::S_WAIT_SOF;
            endcase
            if (resp_load) begin
                state    <= dbgu_pkg::S_SEND;
                resp_len <= resp_len_next;
            end
        end
    end

    // Frame fields, checksum and answer bytes
    always_ff @(posedge clk) begin
        if (rx_fire) begin
            chk_calc <= (state == dbgu_pkg::S_CMD) ? rx_data : (chk_calc ^ rx_data);
            case (state)
                dbgu_pkg::S_CMD: cmd <= rx_data;
                dbgu_pkg::S_A0:  addr_q[7:0]    <= rx_data;
                dbgu_pkg::S_A1:  addr_q[15:8]   <= rx_data;
                dbgu_pkg::S_A2:  addr_q[23:16]  <= rx_data;
                dbgu_pkg::S_A3:  addr_q[31:24]  <= rx_data;
                dbgu_pkg::S_D0:  wdata_q[7:0]   <= rx_data;
                dbgu_pkg::S_D1:  wdata_q[15:8]  <= rx_data;
                dbgu_pkg::S_D2:  wdata_q[23:16] <= rx_data;
                dbgu_pkg::S_D3:  wdata_q[31:24] <= rx_data;
                dbgu_pkg::S_REG: reg_idx        <= rx_data[4:0];
                default: begin
                end
            endcase
        end
        if (resp_load) begin
            resp <= resp_next;
        end
        if (send_go) begin
            tx_data <= resp[resp_idx];
        end
    end

    a_tx_hold: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)));

    a_we_pulse: assert property (@(posedge clk) disable iff (rst)
        bus_req.we |=> !bus_req.we);

endmodule

`default_nettype wire

//--- src/dbg_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbgu_defines.svh"

module dbg_mem (
    input  logic                   clk,
    input  dbgu_pkg::dbg_bus_req_t bus_req,
    output dbgu_pkg::word_t        bus_rdata
);

    localparam int AW = $clog2(`DBGU_MEM_WORDS);

    dbgu_pkg::word_t mem [`DBGU_MEM_WORDS];
    logic [AW-1:0]   idx;

    // Word addressed, byte offset bits dropped
    assign idx = bus_req.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (bus_req.we) begin
            mem[idx] <= bus_req.wdata;
        end
        bus_rdata <= mem[idx];
    end

endmodule

`default_nettype wire

//--- src/core_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module core_regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               core_we,
    input  dbgu_pkg::reg_idx_t core_waddr,
    input  dbgu_pkg::word_t    core_wdata,
    input  dbgu_pkg::reg_idx_t reg_idx,
    output dbgu_pkg::word_t    reg_rdata
);

    dbgu_pkg::word_t regs [32];

    // Register 0 is never written after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (core_we && core_waddr != '0) begin
            regs[core_waddr] <= core_wdata;
        end
    end

    assign reg_rdata = regs[reg_idx];

endmodule

`default_nettype wire

//--- src/dbgu_top.sv
`timescale 1ns/1ps
`default_nettype none

module dbgu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               uart_rxd,
    output logic               uart_txd,
    output logic               hold_core,
    input  logic               core_we,
    input  dbgu_pkg::reg_idx_t core_waddr,
    input  dbgu_pkg::word_t    core_wdata
);

    dbgu_pkg::byte_t        rx_data;
    logic                   rx_valid;
    logic                   rx_ready;
    dbgu_pkg::byte_t        tx_data;
    logic                   tx_valid;
    logic                   tx_ready;
    dbgu_pkg::dbg_bus_req_t bus_req;
    dbgu_pkg::word_t        bus_rdata;
    dbgu_pkg::reg_idx_t     reg_idx;
    dbgu_pkg::word_t        reg_rdata;

    uart_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (uart_rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (uart_txd)
    );

    dbg_cmd_engine u_engine (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .bus_req   (bus_req),
        .bus_rdata (bus_rdata),
        .reg_idx   (reg_idx),
        .reg_rdata (reg_rdata),
        .hold_core (hold_core)
    );

    dbg_mem u_mem (
        .clk       (clk),
        .bus_req   (bus_req),
        .bus_rdata (bus_rdata)
    );

    core_regfile u_regs (
        .clk        (clk),
        .rst        (rst),
        .core_we    (core_we),
        .core_waddr (core_waddr),
        .core_wdata (core_wdata),
        .reg_idx    (reg_idx),
        .reg_rdata  (reg_rdata)
    );

endmodule

`default_nettype wire

//--- sim/tb_dbgu.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbgu_defines.svh"

module tb_dbgu;

    localparam int CLKS = `DBGU_CLKS_PER_BIT;

    logic               clk;
    logic               rst;
    logic               uart_rxd;
    logic               uart_txd;
    logic               hold_core;
    logic               core_we;
    dbgu_pkg::reg_idx_t core_waddr;
    dbgu_pkg::word_t    core_wdata;

    logic [7:0]   tx_frame[$];
    logic [7:0]   exp_ans[$];
    logic [7:0]   got_ans[$];
    string        cur_test;
    int           errors;
    int           tests;
    logic         exp_hold;
    integer       seed;
    integer       fd;
    integer       code;
    integer       n;
    logic [255:0] name;
    logic [1023:0] line;
    logic [7:0]   b;
    logic         done;
    logic [31:0]  rnd_addr;
    logic [31:0]  rnd_data;

    dbgu_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .uart_rxd   (uart_rxd),
        .uart_txd   (uart_txd),
        .hold_core  (hold_core),
        .core_we    (core_we),
        .core_waddr (core_waddr),
        .core_wdata (core_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED: %0s expected %h actual %h", test_name, expected, actual);
            errors++;
        end
    endtask

    // Highest nonzero byte of a scanned token is its first character
    function automatic logic [7:0] first_char(input logic [255:0] v);
        logic [7:0] c;
        c = 8'h00;
        for (int i = 0; i < 32; i++) begin
            if (v[i*8 +: 8] != 8'h00) begin
                c = v[i*8 +: 8];
            end
        end
        return c;
    endfunction

    // XOR of every byte after the start byte
    function automatic logic [7:0] xor_tail(input logic [7:0] q[$]);
        logic [7:0] x;
        x = 8'h00;
        for (int i = 1; i < q.size(); i++) begin
            x = x ^ q[i];
        end
        return x;
    endfunction

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rxd <= bits[i];
            repeat (CLKS) @(posedge clk);
        end
    endtask

    task automatic drive_frame();
        @(posedge clk);
        foreach (tx_frame[i]) begin
            send_byte(tx_frame[i]);
        end
    endtask

    task automatic recv_byte(input int limit, output logic [7:0] data, output logic ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        data = 8'h00;
        @(negedge clk);
        while (uart_txd !== 1'b0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (uart_txd !== 1'b0) begin
            $display("ERROR: %0s no start bit on uart_txd within %0d cycles", cur_test, limit);
            errors++;
        end else begin
            // Move to mid-bit, then step one bit period at a time
            repeat (CLKS / 2) @(negedge clk);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS) @(negedge clk);
                data[i] = uart_txd;
            end
            repeat (CLKS) @(negedge clk);
            if (uart_txd !== 1'b1) begin
                $display("ERROR: %0s stop bit missing on uart_txd", cur_test);
                errors++;
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic collect_answer(input int first_limit);
        logic [7:0] data;
        logic       ok;
        int         limit;
        got_ans.delete();
        for (int i = 0; i < exp_ans.size(); i++) begin
            limit = (i == 0) ? first_limit : 30 * CLKS;
            recv_byte(limit, data, ok);
            if (!ok) begin
                break;
            end
            got_ans.push_back(data);
        end
    endtask

    task automatic run_exchange();
        logic [7:0] cmd;
        int         sof_at;
        sof_at = -1;
        fork
            drive_frame();
            collect_answer((tx_frame.size() + 2) * 10 * CLKS);
        join
        check_value({cur_test, " length"}, exp_ans.size(), got_ans.size());
        for (int i = 0; i < got_ans.size() && i < exp_ans.size(); i++) begin
            check_value($sformatf("%0s byte %0d", cur_test, i), exp_ans[i], got_ans[i]);
        end
        // Run and halt change the hold only when acknowledged with ok
        for (int i = 0; i < tx_frame.size(); i++) begin
            if (sof_at < 0 && tx_frame[i] == `DBGU_SOF) begin
                sof_at = i;
            end
        end
        cmd = (sof_at >= 0 && sof_at + 1 < tx_frame.size()) ? tx_frame[sof_at + 1] : 8'h00;
        if (exp_ans.size() >= 3 && exp_ans[1] == `DBGU_R_ACK && exp_ans[2] == `DBGU_ST_OK) begin
            if (cmd == `DBGU_CMD_RUN) begin
                exp_hold = 1'b0;
            end else if (cmd == `DBGU_CMD_HALT) begin
                exp_hold = 1'b1;
            end
        end
        @(negedge clk);
        check_value({cur_test, " hold_core"}, exp_hold, hold_core);
    endtask

    task automatic load_registers();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            core_we    <= 1'b1;
            core_waddr <= r[4:0];
            core_wdata <= (r == 0) ? 32'hA5A5_5A5A : r * 32'h0101_0101;
        end
        @(posedge clk);
        core_we <= 1'b0;
    endtask

    initial begin
        errors     = 0;
        tests      = 0;
        exp_hold   = 1'b1;
        seed       = 32'h504f4f96;
        rst        <= 1'b1;
        uart_rxd   <= 1'b1;
        core_we    <= 1'b0;
        core_waddr <= '0;
        core_wdata <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset hold_core", 1'b1, hold_core);
        load_registers();

        fd = $fopen("sim/dbgu_golden.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open sim/dbgu_golden.txt");
            errors++;
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", name);
                if (code != 1) begin
                    done = 1'b1;
                end else if (first_char(name) == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    tx_frame.delete();
                    exp_ans.delete();
                    code = $fscanf(fd, "%d", n);
                    for (int k = 0; k < n; k++) begin
                        code = $fscanf(fd, "%h", b);
                        tx_frame.push_back(b);
                    end
                    code = $fscanf(fd, "%d", n);
                    for (int k = 0; k < n; k++) begin
                        code = $fscanf(fd, "%h", b);
                        exp_ans.push_back(b);
                    end
                    cur_test = $sformatf("%0s", name);
                    tests++;
                    run_exchange();
                end
            end
            $fclose(fd);
        end

        // Random word written and read back while halted
        rnd_addr = 32'h0000_0200;
        rnd_data = $random(seed);
        cur_test = "rand_wr";
        tx_frame.delete();
        tx_frame.push_back(`DBGU_SOF);
        tx_frame.push_back(`DBGU_CMD_WR32);
        for (int k = 0; k < 4; k++) tx_frame.push_back(rnd_addr[k*8 +: 8]);
        for (int k = 0; k < 4; k++) tx_frame.push_back(rnd_data[k*8 +: 8]);
        tx_frame.push_back(xor_tail(tx_frame));
        exp_ans.delete();
        exp_ans.push_back(`DBGU_RSOF);
        exp_ans.push_back(`DBGU_R_ACK);
        exp_ans.push_back(`DBGU_ST_OK);
        exp_ans.push_back(`DBGU_R_ACK ^ `DBGU_ST_OK);
        tests++;
        run_exchange();

        cur_test = "rand_rd";
        tx_frame.delete();
        tx_frame.push_back(`DBGU_SOF);
        tx_frame.push_back(`DBGU_CMD_RD32);
        for (int k = 0; k < 4; k++) tx_frame.push_back(rnd_addr[k*8 +: 8]);
        tx_frame.push_back(xor_tail(tx_frame));
        exp_ans.delete();
        exp_ans.push_back(`DBGU_RSOF);
        exp_ans.push_back(`DBGU_R_RD);
        for (int k = 0; k < 4; k++) exp_ans.push_back(rnd_data[k*8 +: 8]);
        exp_ans.push_back(xor_tail(exp_ans));
        tests++;
        run_exchange();

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/dbgu_golden.txt
# name  frame_len  frame_bytes...  answer_len  answer_bytes...
# lengths are decimal, bytes are hex in wire order
run_0 3 A5 12 12 4 5A 90 00 90
halt_0 3 A5 13 13 4 5A 90 00 90
bad_run 3 A5 12 00 4 5A 90 01 91
wr_a 11 A5 10 40 00 00 00 44 33 22 11 14 4 5A 90 00 90
rd_a 7 A5 11 40 00 00 00 51 7 5A 91 44 33 22 11 D5
wr_b 11 A5 10 FC 03 00 00 0D F0 FE CA 26 4 5A 90 00 90
rd_b 7 A5 11 FC 03 00 00 EE 7 5A 91 0D F0 FE CA 58
run_1 3 A5 12 12 4 5A 90 00 90
wr_busy 11 A5 10 40 00 00 00 EF BE AD DE 72 4 5A 90 02 92
rd_busy 7 A5 11 40 00 00 00 51 4 5A 90 02 92
rdreg_run 4 A5 14 07 13 7 5A 92 07 07 07 07 92
halt_1 3 A5 13 13 4 5A 90 00 90
rd_after_busy 7 A5 11 40 00 00 00 51 7 5A 91 44 33 22 11 D5
bad_chk 11 A5 10 40 00 00 00 00 00 00 00 51 4 5A 90 01 91
rd_after_bad 7 A5 11 40 00 00 00 51 7 5A 91 44 33 22 11 D5
bad_cmd 7 A5 20 40 00 00 00 60 4 5A 90 03 93
rdreg_0 4 A5 14 00 14 7 5A 92 00 00 00 00 92
rdreg_31 4 A5 14 1F 0B 7 5A 92 1F 1F 1F 1F 92
rdreg_1 4 A5 14 01 15 7 5A 92 01 01 01 01 92
noise_run 6 00 FF 3C A5 12 12 4 5A 90 00 90
noise_halt 5 5A 77 A5 13 13 4 5A 90 00 90

//--- filelist.f
+incdir+include
src/dbgu_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/dbg_cmd_engine.sv
src/dbg_mem.sv
src/core_regfile.sv
src/dbgu_top.sv
sim/tb_dbgu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the debug port simulation with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_dbgu --Mdir obj_dir -o sim_dbgu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_dbgu 2>&1 | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "Simulation exited with an error"
    exit 1
fi

if grep -qF '** FAIL **' "$LOG"; then
    exit 1
fi
if ! grep -qF '** PASS **' "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
